// File: verilog/rv32i_pkg.sv
package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes handled by the issue stage
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_e;

    typedef enum logic [2:0] {
        f3_add  = 3'b000,  // Also sub
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,  // srl and sra
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_funct3_e;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_e;

    // Same code as funct3
    typedef enum logic [2:0] {
        cmp_slt  = 3'b010,
        cmp_sltu = 3'b011
    } cmp_op_e;

endpackage

// File: verilog/tomasulo_pkg.sv
package tomasulo_pkg;

    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = 4;  // Tag 0 means no producer

    typedef logic [TAG_W-1:0] rob_tag_t;

    typedef struct packed {
        logic [rv32i_pkg::XLEN-1:0] pc;
        logic [rv32i_pkg::XLEN-1:0] instr;
    } iq_entry_t;

    typedef struct packed {
        logic                       ready;
        rob_tag_t                   tag;
        logic [rv32i_pkg::XLEN-1:0] value;
    } operand_t;

    typedef struct packed {
        logic                       ready;
        logic [rv32i_pkg::XLEN-1:0] value;
    } rob_entry_t;

    typedef rob_entry_t [ROB_DEPTH-1:0] rob_view_t;

    typedef struct packed {
        logic [rv32i_pkg::XLEN-1:0] vj;
        rob_tag_t                   qj;
        logic [rv32i_pkg::XLEN-1:0] vk;
        rob_tag_t                   qk;
    } regfile_rd_t;

    typedef enum logic [1:0] {
        cls_none = 2'd0,
        cls_alu  = 2'd1,
        cls_cmp  = 2'd2
    } instr_class_e;

    typedef struct packed {
        instr_class_e                     cls;
        rv32i_pkg::alu_op_e               alu_op;
        rv32i_pkg::cmp_op_e               cmp_op;
        rv32i_pkg::rv32i_opcode_e         opcode;
        logic [rv32i_pkg::REG_ADDR_W-1:0] rd;
        logic                             uses_rs1;
        logic                             uses_rs2;
        logic [rv32i_pkg::XLEN-1:0]       imm;
        logic                             op1_pc;  // Unused rs1 becomes PC, else zero
        logic [rv32i_pkg::XLEN-1:0]       pc;
    } decoded_t;

    typedef struct packed {
        logic               valid;
        rv32i_pkg::alu_op_e op;
        operand_t           src1;
        operand_t           src2;
        rob_tag_t           tag;
    } alu_rs_entry_t;

    typedef struct packed {
        logic               valid;
        rv32i_pkg::cmp_op_e op;
        operand_t           src1;
        operand_t           src2;
        rob_tag_t           tag;
    } cmp_rs_entry_t;

    typedef struct packed {
        logic                             valid;
        logic [rv32i_pkg::XLEN-1:0]       pc;
        rv32i_pkg::rv32i_opcode_e         opcode;
        logic [rv32i_pkg::REG_ADDR_W-1:0] rd;
    } rob_alloc_t;

    typedef struct packed {
        logic                             valid;
        logic [rv32i_pkg::REG_ADDR_W-1:0] rd;
        rob_tag_t                         tag;
    } rat_update_t;

endpackage

// File: verilog/instr_decoder.sv
module instr_decoder (
    input  tomasulo_pkg::iq_entry_t           iq_head_i,
    output tomasulo_pkg::decoded_t            dec_o,
    output logic [rv32i_pkg::REG_ADDR_W-1:0]  rs1_o,
    output logic [rv32i_pkg::REG_ADDR_W-1:0]  rs2_o
);

    logic [rv32i_pkg::XLEN-1:0] instr;
    logic [2:0]                 funct3;
    logic                       funct7_5;
    logic                       is_reg;
    rv32i_pkg::rv32i_opcode_e   opcode;
    logic [rv32i_pkg::XLEN-1:0] i_imm;
    logic [rv32i_pkg::XLEN-1:0] u_imm;

    assign instr    = iq_head_i.instr;
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];
    assign opcode   = rv32i_pkg::rv32i_opcode_e'(instr[6:0]);
    assign is_reg   = (opcode == rv32i_pkg::op_reg);
    assign i_imm    = {{20{instr[31]}}, instr[31:20]};
    assign u_imm    = {instr[31:12], 12'h000};

    assign rs1_o = instr[19:15];
    assign rs2_o = instr[24:20];

    always_comb begin
        dec_o.cls      = tomasulo_pkg::cls_none;
        dec_o.alu_op   = rv32i_pkg::alu_add;
        dec_o.cmp_op   = rv32i_pkg::cmp_slt;
        dec_o.opcode   = opcode;
        dec_o.rd       = instr[11:7];
        dec_o.uses_rs1 = 1'b0;
        dec_o.uses_rs2 = 1'b0;
        dec_o.imm      = i_imm;
        dec_o.op1_pc   = 1'b0;
        dec_o.pc       = iq_head_i.pc;

        case (opcode)
            rv32i_pkg::op_lui: begin
                dec_o.cls = tomasulo_pkg::cls_alu;  // 0 + imm
                dec_o.imm = u_imm;
            end

            rv32i_pkg::op_auipc: begin
                dec_o.cls    = tomasulo_pkg::cls_alu;  // PC + imm
                dec_o.imm    = u_imm;
                dec_o.op1_pc = 1'b1;
            end

            rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
                dec_o.uses_rs1 = 1'b1;
                dec_o.uses_rs2 = is_reg;
                case (rv32i_pkg::arith_funct3_e'(funct3))
                    rv32i_pkg::f3_slt, rv32i_pkg::f3_sltu: begin
                        dec_o.cls    = tomasulo_pkg::cls_cmp;
                        dec_o.cmp_op = rv32i_pkg::cmp_op_e'(funct3);
                    end
                    rv32i_pkg::f3_add: begin
                        // No SUBI, bit 30 of an I-immediate is data
                        dec_o.cls    = tomasulo_pkg::cls_alu;
                        dec_o.alu_op = rv32i_pkg::alu_op_e'({funct7_5 & is_reg, funct3});
                    end
                    rv32i_pkg::f3_sr: begin
                        dec_o.cls    = tomasulo_pkg::cls_alu;
                        dec_o.alu_op = rv32i_pkg::alu_op_e'({funct7_5, funct3});
                    end
                    default: begin
                        dec_o.cls    = tomasulo_pkg::cls_alu;
                        dec_o.alu_op = rv32i_pkg::alu_op_e'({1'b0, funct3});
                    end
                endcase
            end

            default: ;  // Anything else is dropped by dispatch
        endcase
    end

endmodule

// File: verilog/operand_bypass.sv
module operand_bypass (
    input  tomasulo_pkg::regfile_rd_t regfile_rd_i,
    input  tomasulo_pkg::rob_view_t   rob_view_i,
    output tomasulo_pkg::operand_t    op_a_o,
    output tomasulo_pkg::operand_t    op_b_o
);

    // Take a finished ROB result over the stale register file value
    function automatic tomasulo_pkg::operand_t pick_src(
        input logic [rv32i_pkg::XLEN-1:0] rf_value,
        input tomasulo_pkg::rob_tag_t     rf_tag,
        input tomasulo_pkg::rob_view_t    rob
    );
        tomasulo_pkg::operand_t op;
        if (rf_tag != '0 && rob[rf_tag].ready) begin
            op.ready = 1'b1;
            op.tag   = '0;
            op.value = rob[rf_tag].value;
        end else begin
            op.ready = (rf_tag == '0);
            op.tag   = rf_tag;
            op.value = rf_value;
        end
        return op;
    endfunction

    always_comb begin
        op_a_o = pick_src(regfile_rd_i.vj, regfile_rd_i.qj, rob_view_i);
        op_b_o = pick_src(regfile_rd_i.vk, regfile_rd_i.qk, rob_view_i);
    end

endmodule

// File: verilog/dispatch_ctrl.sv
module dispatch_ctrl (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        iq_empty_i,
    input  tomasulo_pkg::decoded_t      dec_i,
    input  tomasulo_pkg::operand_t      op_a_i,
    input  tomasulo_pkg::operand_t      op_b_i,
    input  tomasulo_pkg::rob_tag_t      rob_free_tag_i,
    input  logic                        rob_full_i,
    input  logic                        alu_rs_full_i,
    input  logic                        cmp_rs_full_i,
    output logic                        iq_pop_o,
    output tomasulo_pkg::alu_rs_entry_t alu_issue_o,
    output tomasulo_pkg::cmp_rs_entry_t cmp_issue_o,
    output tomasulo_pkg::rob_alloc_t    rob_alloc_o,
    output tomasulo_pkg::rat_update_t   rat_update_o
);

    logic                   is_cmp;
    logic                   slot_ok;
    logic                   discard;
    logic                   rs_full;
    logic                   accept;
    tomasulo_pkg::operand_t src1;
    tomasulo_pkg::operand_t src2;

    logic                             alu_vld_q;
    logic                             cmp_vld_q;
    logic                             alloc_vld_q;
    tomasulo_pkg::operand_t           src1_q;
    tomasulo_pkg::operand_t           src2_q;
    rv32i_pkg::alu_op_e               alu_op_q;
    rv32i_pkg::cmp_op_e               cmp_op_q;
    tomasulo_pkg::rob_tag_t           tag_q;
    logic [rv32i_pkg::XLEN-1:0]       pc_q;
    rv32i_pkg::rv32i_opcode_e         opcode_q;
    logic [rv32i_pkg::REG_ADDR_W-1:0] rd_q;

    assign is_cmp  = (dec_i.cls == tomasulo_pkg::cls_cmp);
    assign slot_ok = !iq_empty_i && !flush_i && !rob_full_i;
    assign discard = (dec_i.rd == '0) || (dec_i.cls == tomasulo_pkg::cls_none);
    assign rs_full = is_cmp ? cmp_rs_full_i : alu_rs_full_i;
    assign accept  = slot_ok && !discard && !rs_full && (rob_free_tag_i != '0);

    // Discards leave the queue without needing a station or a tag
    assign iq_pop_o = accept || (slot_ok && discard);

    always_comb begin
        src1 = op_a_i;
        if (!dec_i.uses_rs1) begin
            src1.ready = 1'b1;
            src1.tag   = '0;
            src1.value = dec_i.op1_pc ? dec_i.pc : '0;
        end
        src2 = op_b_i;
        if (!dec_i.uses_rs2) begin
            src2.ready = 1'b1;  // Immediate
            src2.tag   = '0;
            src2.value = dec_i.imm;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_vld_q   <= 1'b0;
            cmp_vld_q   <= 1'b0;
            alloc_vld_q <= 1'b0;
        end else begin
            alu_vld_q   <= accept && !is_cmp;
            cmp_vld_q   <= accept && is_cmp;
            alloc_vld_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            src1_q   <= src1;
            src2_q   <= src2;
            alu_op_q <= dec_i.alu_op;
            cmp_op_q <= dec_i.cmp_op;
            tag_q    <= rob_free_tag_i;
            pc_q     <= dec_i.pc;
            opcode_q <= dec_i.opcode;
            rd_q     <= dec_i.rd;
        end
    end

    always_comb begin
        alu_issue_o.valid   = alu_vld_q;
        alu_issue_o.op      = alu_op_q;
        alu_issue_o.src1    = src1_q;
        alu_issue_o.src2    = src2_q;
        alu_issue_o.tag     = tag_q;
        cmp_issue_o.valid   = cmp_vld_q;
        cmp_issue_o.op      = cmp_op_q;
        cmp_issue_o.src1    = src1_q;
        cmp_issue_o.src2    = src2_q;
        cmp_issue_o.tag     = tag_q;
        rob_alloc_o.valid   = alloc_vld_q;
        rob_alloc_o.pc      = pc_q;
        rob_alloc_o.opcode  = opcode_q;
        rob_alloc_o.rd      = rd_q;
        rat_update_o.valid  = alloc_vld_q;  // Rename with the same tag as the ROB slot
        rat_update_o.rd     = rd_q;
        rat_update_o.tag    = tag_q;
    end

    a_one_station: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(alu_issue_o.valid && cmp_issue_o.valid))
        else $error("issue to both stations");

    a_tag_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        rob_alloc_o.valid |-> (rat_update_o.tag != '0))
        else $error("issued without a valid ROB tag");

endmodule

// File: verilog/issue_stage.sv
module issue_stage (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              flush_i,
    input  tomasulo_pkg::iq_entry_t           iq_head_i,
    input  logic                              iq_empty_i,
    output logic                              iq_pop_o,
    input  tomasulo_pkg::regfile_rd_t         regfile_rd_i,
    output logic [rv32i_pkg::REG_ADDR_W-1:0]  rs1_o,
    output logic [rv32i_pkg::REG_ADDR_W-1:0]  rs2_o,
    input  tomasulo_pkg::rob_view_t           rob_view_i,
    input  tomasulo_pkg::rob_tag_t            rob_free_tag_i,
    input  logic                              rob_full_i,
    input  logic                              alu_rs_full_i,
    input  logic                              cmp_rs_full_i,
    output tomasulo_pkg::alu_rs_entry_t       alu_issue_o,
    output tomasulo_pkg::cmp_rs_entry_t       cmp_issue_o,
    output tomasulo_pkg::rob_alloc_t          rob_alloc_o,
    output tomasulo_pkg::rat_update_t         rat_update_o
);

    tomasulo_pkg::decoded_t dec;
    tomasulo_pkg::operand_t op_a;
    tomasulo_pkg::operand_t op_b;

    instr_decoder u_instr_decoder (
        .iq_head_i (iq_head_i),
        .dec_o     (dec),
        .rs1_o     (rs1_o),
        .rs2_o     (rs2_o)
    );

    operand_bypass u_operand_bypass (
        .regfile_rd_i (regfile_rd_i),
        .rob_view_i   (rob_view_i),
        .op_a_o       (op_a),
        .op_b_o       (op_b)
    );

    dispatch_ctrl u_dispatch_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .iq_empty_i     (iq_empty_i),
        .dec_i          (dec),
        .op_a_i         (op_a),
        .op_b_i         (op_b),
        .rob_free_tag_i (rob_free_tag_i),
        .rob_full_i     (rob_full_i),
        .alu_rs_full_i  (alu_rs_full_i),
        .cmp_rs_full_i  (cmp_rs_full_i),
        .iq_pop_o       (iq_pop_o),
        .alu_issue_o    (alu_issue_o),
        .cmp_issue_o    (cmp_issue_o),
        .rob_alloc_o    (rob_alloc_o),
        .rat_update_o   (rat_update_o)
    );

endmodule

// File: tb/clk_gen.sv
module clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;  // Released on an edge
    end

endmodule

// File: tb/tb_issue_stage.sv
module tb_issue_stage;

    typedef struct packed {
        logic [31:0] instr;
        logic [3:0]  qj;
        logic [3:0]  qk;
        logic [1:0]  rob_rdy;  // {rs1, rs2} ROB entry finished
        logic [4:0]  stall;    // {flush, no tag, rob full, cmp full, alu full}
        logic [1:0]  cls;      // 0 dropped, 1 ALU, 2 compare
        logic [3:0]  op;
        logic [31:0] a;
        logic        a_rdy;
        logic [31:0] b;
        logic        b_rdy;
    } row_t;

    localparam int NUM_ROWS = 31;
    localparam row_t ROWS [NUM_ROWS] = '{
        '{32'h002081b3, 0, 0, 2'b00, 5'b00000, 1, 4'h0, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h40208233, 0, 0, 2'b00, 5'b00000, 1, 4'h8, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h004192b3, 0, 0, 2'b00, 5'b00000, 1, 4'h1, 32'h03030303, 1, 32'h04040404, 1},
        '{32'h0020c333, 0, 0, 2'b00, 5'b00000, 1, 4'h4, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h0020d3b3, 0, 0, 2'b00, 5'b00000, 1, 4'h5, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h4020d433, 0, 0, 2'b00, 5'b00000, 1, 4'hd, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h0020e4b3, 0, 0, 2'b00, 5'b00000, 1, 4'h6, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h0020f533, 0, 0, 2'b00, 5'b00000, 1, 4'h7, 32'h01010101, 1, 32'h02020202, 1},
        '{32'hfff08593, 0, 0, 2'b00, 5'b00000, 1, 4'h0, 32'h01010101, 1, 32'hffffffff, 1},
        '{32'h40010613, 0, 0, 2'b00, 5'b00000, 1, 4'h0, 32'h02020202, 1, 32'h00000400, 1},
        '{32'h4030d693, 0, 0, 2'b00, 5'b00000, 1, 4'hd, 32'h01010101, 1, 32'h00000403, 1},
        '{32'h0ff14713, 0, 0, 2'b00, 5'b00000, 1, 4'h4, 32'h02020202, 1, 32'h000000ff, 1},
        '{32'h0020a7b3, 0, 0, 2'b00, 5'b00000, 2, 4'h2, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h00113833, 0, 0, 2'b00, 5'b00000, 2, 4'h3, 32'h02020202, 1, 32'h01010101, 1},
        '{32'hffb0a893, 0, 0, 2'b00, 5'b00000, 2, 4'h2, 32'h01010101, 1, 32'hfffffffb, 1},
        '{32'h0071b913, 0, 0, 2'b00, 5'b00000, 2, 4'h3, 32'h03030303, 1, 32'h00000007, 1},
        '{32'h123459b7, 0, 0, 2'b00, 5'b00000, 1, 4'h0, 32'h00000000, 1, 32'h12345000, 1},
        '{32'hfedcba17, 0, 0, 2'b00, 5'b00000, 1, 4'h0, 32'h00000000, 1, 32'hfedcb000, 1},
        '{32'h002081b3, 5, 9, 2'b10, 5'b00000, 1, 4'h0, 32'hab050505, 1, 32'h02020202, 0},
        '{32'h002081b3, 7, 12, 2'b01, 5'b00000, 1, 4'h0, 32'h01010101, 0, 32'hab0c0c0c, 1},
        '{32'hfff08593, 3, 6, 2'b00, 5'b00000, 1, 4'h0, 32'h01010101, 0, 32'hffffffff, 1},
        '{32'h00208033, 0, 0, 2'b00, 5'b00001, 0, 4'h0, 32'h00000000, 1, 32'h00000000, 1},
        '{32'h0000a183, 0, 0, 2'b00, 5'b00000, 0, 4'h0, 32'h00000000, 1, 32'h00000000, 1},
        '{32'h00208033, 0, 0, 2'b00, 5'b00100, 0, 4'h0, 32'h00000000, 1, 32'h00000000, 1},
        '{32'h002081b3, 0, 0, 2'b00, 5'b00001, 1, 4'h0, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h0020a7b3, 0, 0, 2'b00, 5'b00010, 2, 4'h2, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h002081b3, 0, 0, 2'b00, 5'b00100, 1, 4'h0, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h002081b3, 0, 0, 2'b00, 5'b01000, 1, 4'h0, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h40208233, 0, 0, 2'b00, 5'b10000, 1, 4'h8, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h0020a7b3, 0, 0, 2'b00, 5'b00001, 2, 4'h2, 32'h01010101, 1, 32'h02020202, 1},
        '{32'h002081b3, 0, 0, 2'b00, 5'b00010, 1, 4'h0, 32'h01010101, 1, 32'h02020202, 1}
    };

    logic                             clk;
    logic                             rst_n;
    logic                             flush;
    logic                             iq_empty;
    logic                             iq_pop;
    logic                             rob_full;
    logic                             alu_full;
    logic                             cmp_full;
    logic [3:0]                       cur_qj;
    logic [3:0]                       cur_qk;
    logic [1:0]                       cur_rdy;
    logic [rv32i_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv32i_pkg::REG_ADDR_W-1:0] rs2;
    tomasulo_pkg::rob_tag_t           free_tag;
    tomasulo_pkg::iq_entry_t          iq_head;
    tomasulo_pkg::regfile_rd_t        regfile_rd;
    tomasulo_pkg::rob_view_t          rob_view;
    tomasulo_pkg::alu_rs_entry_t      alu_issue;
    tomasulo_pkg::cmp_rs_entry_t      cmp_issue;
    tomasulo_pkg::rob_alloc_t         rob_alloc;
    tomasulo_pkg::rat_update_t        rat_update;

    clk_gen #(.PERIOD(100), .RST_CYCLES(16)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    issue_stage u_issue_stage (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .flush_i        (flush),
        .iq_head_i      (iq_head),
        .iq_empty_i     (iq_empty),
        .iq_pop_o       (iq_pop),
        .regfile_rd_i   (regfile_rd),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .rob_view_i     (rob_view),
        .rob_free_tag_i (free_tag),
        .rob_full_i     (rob_full),
        .alu_rs_full_i  (alu_full),
        .cmp_rs_full_i  (cmp_full),
        .alu_issue_o    (alu_issue),
        .cmp_issue_o    (cmp_issue),
        .rob_alloc_o    (rob_alloc),
        .rat_update_o   (rat_update)
    );

    // Register file and ROB model answer at once
    always_comb begin
        regfile_rd.vj = 32'(rs1) * 32'h01010101;
        regfile_rd.qj = cur_qj;
        regfile_rd.vk = 32'(rs2) * 32'h01010101;
        regfile_rd.qk = cur_qk;
        for (int t = 0; t < tomasulo_pkg::ROB_DEPTH; t++) begin
            rob_view[t].ready = (t == cur_qj && cur_rdy[1]) || (t == cur_qk && cur_rdy[0]);
            rob_view[t].value = 32'hab000000 + t * 32'h00010101;
        end
    end

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %0h, expected %0h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    endtask

    // Stall rules as seen from outside the stage
    function automatic logic is_held(input row_t r);
        logic rs_full;
        rs_full = (r.cls == 2) ? r.stall[1] : r.stall[0];
        return r.stall[4] || r.stall[2] || (r.cls != 0 && (r.stall[3] || rs_full));
    endfunction

    task automatic expect_idle();
        check_equal("iq_pop_o", iq_pop, 0);
        check_equal("alu_issue_o.valid", alu_issue.valid, 0);
        check_equal("cmp_issue_o.valid", cmp_issue.valid, 0);
        check_equal("rob_alloc_o.valid", rob_alloc.valid, 0);
        check_equal("rat_update_o.valid", rat_update.valid, 0);
    endtask

    task automatic expect_issue(input row_t r, input logic [31:0] pc,
                                input tomasulo_pkg::rob_tag_t tag);
        tomasulo_pkg::operand_t exp_a;
        tomasulo_pkg::operand_t exp_b;
        exp_a.ready = r.a_rdy;
        exp_a.tag   = r.a_rdy ? '0 : r.qj;
        exp_a.value = (r.instr[6:0] == 7'h17) ? pc : r.a;  // AUIPC
        exp_b.ready = r.b_rdy;
        exp_b.tag   = r.b_rdy ? '0 : r.qk;
        exp_b.value = r.b;
        check_equal("alu_issue_o.valid", alu_issue.valid, r.cls == 1);
        check_equal("cmp_issue_o.valid", cmp_issue.valid, r.cls == 2);
        check_equal("rob_alloc_o.valid", rob_alloc.valid, r.cls != 0);
        check_equal("rat_update_o.valid", rat_update.valid, r.cls != 0);
        if (r.cls == 1) begin
            check_equal("alu_issue_o.op", alu_issue.op, r.op);
            check_equal("alu_issue_o.src1", alu_issue.src1, exp_a);
            check_equal("alu_issue_o.src2", alu_issue.src2, exp_b);
            check_equal("alu_issue_o.tag", alu_issue.tag, tag);
        end
        if (r.cls == 2) begin
            check_equal("cmp_issue_o.op", cmp_issue.op, r.op);
            check_equal("cmp_issue_o.src1", cmp_issue.src1, exp_a);
            check_equal("cmp_issue_o.src2", cmp_issue.src2, exp_b);
            check_equal("cmp_issue_o.tag", cmp_issue.tag, tag);
        end
        if (r.cls != 0) begin
            check_equal("rob_alloc_o.pc", rob_alloc.pc, pc);
            check_equal("rob_alloc_o.opcode", rob_alloc.opcode, r.instr[6:0]);
            check_equal("rob_alloc_o.rd", rob_alloc.rd, r.instr[11:7]);
            check_equal("rat_update_o.rd", rat_update.rd, r.instr[11:7]);
            check_equal("rat_update_o.tag", rat_update.tag, tag);
        end
    endtask

    initial begin
        row_t                   r;
        logic [31:0]            pc;
        tomasulo_pkg::rob_tag_t tag;
        int                     waited;
        void'($urandom(32'h34c6));
        flush    = 1'b0;
        iq_empty = 1'b1;
        iq_head  = '0;
        free_tag = '0;
        rob_full = 1'b0;
        alu_full = 1'b0;
        cmp_full = 1'b0;
        cur_qj   = '0;
        cur_qk   = '0;
        cur_rdy  = '0;

        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited == 40) begin
                abort_on_timeout("reset release");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        @(negedge clk);
        expect_idle();

        for (int i = 0; i < NUM_ROWS; i++) begin
            r   = ROWS[i];
            pc  = $urandom & 32'hffff_fffc;
            tag = tomasulo_pkg::rob_tag_t'($urandom % 15 + 1);
            @(posedge clk);
            iq_head.pc    <= pc;
            iq_head.instr <= r.instr;
            iq_empty      <= 1'b0;
            cur_qj        <= r.qj;
            cur_qk        <= r.qk;
            cur_rdy       <= r.rob_rdy;
            flush         <= r.stall[4];
            free_tag      <= r.stall[3] ? '0 : tag;
            rob_full      <= r.stall[2];
            cmp_full      <= r.stall[1];
            alu_full      <= r.stall[0];

            if (is_held(r)) begin
                repeat (3) begin
                    @(negedge clk);
                    expect_idle();  // Head must wait
                end
                @(posedge clk);
                flush    <= 1'b0;
                free_tag <= tag;
                rob_full <= 1'b0;
                cmp_full <= 1'b0;
                alu_full <= 1'b0;
            end

            waited = 0;
            @(negedge clk);
            while (!iq_pop) begin
                if (waited == 20) begin
                    abort_on_timeout("iq_pop_o");
                end else begin
                    waited++;
                    @(negedge clk);
                end
            end

            @(posedge clk);
            iq_empty <= 1'b1;
            @(negedge clk);
            expect_issue(r, pc, tag);
            @(negedge clk);
            expect_idle();  // One cycle pulse only
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: tb.f
verilog/rv32i_pkg.sv
verilog/tomasulo_pkg.sv
verilog/instr_decoder.sv
verilog/operand_bypass.sv
verilog/dispatch_ctrl.sv
verilog/issue_stage.sv
tb/clk_gen.sv
tb/tb_issue_stage.sv

// File: Bender.yml
package:
  name: issue_stage

sources:
  - verilog/rv32i_pkg.sv
  - verilog/tomasulo_pkg.sv
  - verilog/instr_decoder.sv
  - verilog/operand_bypass.sv
  - verilog/dispatch_ctrl.sv
  - verilog/issue_stage.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/tb_issue_stage.sv
